// File: flist.f
jam_pkg.sv
jam_ctrl.sv
perm_engine.sv
cost_scanner.sv
min_tracker.sv
jam_top.sv
tb_clock.sv
jam_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the job-assignment testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
    --top-module jam_tb \
    -f flist.f \
    -o Vjam_tb

out="$(./obj_dir/Vjam_tb)"
echo "$out"

if grep -qxF "Done: no errors" <<< "$out"; then
    exit 0
else
    exit 1
fi

// File: jam_tb.sv
module jam_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int N              = 8;
    localparam int NPERM          = 40320;
    // six searches, generous cycles per permutation
    localparam int TIMEOUT_CYCLES = 6 * NPERM * 24;

    logic            CLK;
    logic            RST;
    logic            reset_req;
    jam_pkg::cost_t  Cost;
    jam_pkg::idx_t   W;
    jam_pkg::idx_t   J;
    jam_pkg::sum_t   MinCost;
    jam_pkg::count_t MatchCount;
    logic            Valid;

    // table seen by the DUT, and the next one being prepared
    jam_pkg::cost_t  cost_tbl  [0:7][0:7];
    jam_pkg::cost_t  stage_tbl [0:7][0:7];

    // expected result of the running test
    string           exp_name;
    jam_pkg::sum_t   exp_sum;
    jam_pkg::count_t exp_cnt;

    int              chk_errors;
    int              mon_errors;
    int              checks;
    int              tests_run;
    int              results_seen;
    int              cycles;
    int              seed;
    int              valid_pulses;
    logic            valid_prev;
    logic            sum_ok;
    logic            cnt_ok;

    // jobs already presented in the current scan
    logic [N-1:0]    jobs_seen;
    jam_pkg::idx_t   w_prev;

    tb_clock u_clk (
        .CLK       (CLK),
        .RST       (RST),
        .reset_req (reset_req)
    );

    jam_top #(
        .N (N)
    ) DUT (
        .CLK        (CLK),
        .RST        (RST),
        .Cost       (Cost),
        .W          (W),
        .J          (J),
        .MinCost    (MinCost),
        .MatchCount (MatchCount),
        .Valid      (Valid)
    );

    // zero-latency table read
    assign Cost = cost_tbl[W][J];

    // ----------------------------------------
    // reference model
    // ----------------------------------------

    // walks all 8! assignments by lehmer code, independent of order
    function automatic void ref_search(input jam_pkg::cost_t tbl [0:7][0:7],
                                       output jam_pkg::sum_t best,
                                       output jam_pkg::count_t hits);
        int avail [0:7];
        int rem;
        int f;
        int d;
        int total;
        int best_i;
        int hits_i;
        best_i = -1;
        hits_i = 0;
        for (int k = 0; k < NPERM; k++) begin
            for (int i = 0; i < 8; i++) begin
                avail[i] = i;
            end
            rem   = k;
            total = 0;
            for (int w = 0; w < 8; w++) begin
                // digit weight is (7 - w)!
                f = 1;
                for (int i = 2; i <= 7 - w; i++) begin
                    f = f * i;
                end
                d   = rem / f;
                rem = rem % f;
                total += int'(tbl[w][avail[d]]);
                // drop the used job
                for (int i = d; i < 7 - w; i++) begin
                    avail[i] = avail[i + 1];
                end
            end
            if (best_i < 0 || total < best_i) begin
                best_i = total;
                hits_i = 1;
            end else if (total == best_i) begin
                hits_i++;
            end
        end
        best = jam_pkg::sum_t'(best_i);
        hits = jam_pkg::count_t'(hits_i);
    endfunction

    // ----------------------------------------
    // compare tasks
    // ----------------------------------------
    task automatic check_sum(input string name, input jam_pkg::sum_t exp,
                             input jam_pkg::sum_t act, output logic ok);
        ok = (act === exp);
        if (!ok) begin
            $display("CHECK FAILED %s: MinCost expected %0d actual %0d", name, exp, act);
            chk_errors++;
        end
    endtask

    task automatic check_count(input string name, input jam_pkg::count_t exp,
                               input jam_pkg::count_t act, output logic ok);
        ok = (act === exp);
        if (!ok) begin
            $display("CHECK FAILED %s: MatchCount expected %0d actual %0d", name, exp, act);
            chk_errors++;
        end
    endtask

    // result strobe seen, compare both outputs
    always @(posedge CLK) begin
        if (!RST && Valid) begin
            check_sum(exp_name, exp_sum, MinCost, sum_ok);
            check_count(exp_name, exp_cnt, MatchCount, cnt_ok);
            checks += 2;
            if (sum_ok && cnt_ok) begin
                $display("test %s: pass, MinCost %0d MatchCount %0d",
                         exp_name, MinCost, MatchCount);
            end else begin
                $display("test %s: fail", exp_name);
            end
            results_seen++;
        end
    end

    // ----------------------------------------
    // monitors
    // ----------------------------------------
    always @(posedge CLK) begin
        if (RST) begin
            valid_prev   <= 1'b0;
            valid_pulses <= 0;
            jobs_seen    <= '0;
            w_prev       <= '0;
            if (Valid) begin
                $display("Valid was high while reset was asserted");
                mon_errors++;
            end
        end else begin
            valid_prev <= Valid;
            w_prev     <= W;
            if (Valid) begin
                valid_pulses <= valid_pulses + 1;
            end
            if (Valid && valid_prev) begin
                $display("test %s: Valid stayed high longer than one cycle", exp_name);
                mon_errors++;
            end else if (Valid && valid_pulses != 0) begin
                $display("test %s: Valid pulsed a second time", exp_name);
                mon_errors++;
            end
            // a scan restarts at worker 0, then moves on one worker per cycle
            if (W == '0) begin
                jobs_seen    <= '0;
                jobs_seen[J] <= 1'b1;
            end else if (W == w_prev + 1'b1) begin
                if (jobs_seen[J]) begin
                    $display("test %s: job %0d given to two workers in one scan",
                             exp_name, J);
                    mon_errors++;
                end
                jobs_seen[J] <= 1'b1;
            end
        end
    end

    // watchdog
    always @(posedge CLK) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, Valid never arrived in test %s",
                     cycles, exp_name);
            $display("Done: errors found");
            $finish;
        end
    end

    // ----------------------------------------
    // stimulus
    // ----------------------------------------

    // kind 0 uniform, 1 zero diagonal, 2 random, 3 parity ties, 4 mod-3 ties
    task automatic fill_table(input int kind);
        for (int w = 0; w < 8; w++) begin
            for (int j = 0; j < 8; j++) begin
                case (kind)
                    0: stage_tbl[w][j] = 7'd5;
                    1: stage_tbl[w][j] = (w == j) ? 7'd0 : 7'd127;
                    2: stage_tbl[w][j] = jam_pkg::cost_t'($random(seed) & 127);
                    3: stage_tbl[w][j] = jam_pkg::cost_t'((w ^ j) & 1);
                    default: stage_tbl[w][j] = ((w + j) % 3 == 0) ? 7'd0 : 7'd1;
                endcase
            end
        end
    endtask

    // load table under reset, release, wait for the result
    task automatic run_case(input string name);
        int target;
        exp_name = name;
        ref_search(stage_tbl, exp_sum, exp_cnt);
        target = results_seen + 1;
        @(posedge CLK);
        for (int w = 0; w < 8; w++) begin
            for (int j = 0; j < 8; j++) begin
                cost_tbl[w][j] <= stage_tbl[w][j];
            end
        end
        reset_req <= 1'b1;
        @(posedge CLK);
        reset_req <= 1'b0;
        @(negedge RST);
        wait (results_seen >= target);
        tests_run++;
        // a few idle cycles so a stray second pulse is caught
        repeat (8) @(posedge CLK);
    endtask

    initial begin
        reset_req    = 1'b0;
        seed         = 91;
        chk_errors   = 0;
        mon_errors   = 0;
        checks       = 0;
        tests_run    = 0;
        results_seen = 0;
        cycles       = 0;
        exp_name     = "power_on";
        exp_sum      = '0;
        exp_cnt      = '0;
        for (int w = 0; w < 8; w++) begin
            for (int j = 0; j < 8; j++) begin
                cost_tbl[w][j]  = '0;
                stage_tbl[w][j] = '0;
            end
        end

        fill_table(0);
        run_case("uniform");
        fill_table(1);
        run_case("zero_diagonal");
        fill_table(2);
        run_case("random_a");
        fill_table(2);
        run_case("random_b");
        fill_table(3);
        run_case("parity_ties");
        fill_table(4);
        run_case("mod3_ties");

        $display("tests %0d, checks %0d, errors %0d",
                 tests_run, checks, chk_errors + mon_errors);
        if (chk_errors + mon_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: tb_clock.sv
module tb_clock (
    output logic CLK,
    output logic RST,
    input  logic reset_req
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int RST_CYCLES = 10;

    int rst_left;

    initial begin
        CLK      = 1'b0;
        RST      = 1'b1;
        rst_left = RST_CYCLES;
    end

    // 8 ns period
    always #4 CLK = ~CLK;

    // reset held for RST_CYCLES edges after power-on or a request
    always @(posedge CLK) begin
        if (reset_req) begin
            RST      <= 1'b1;
            rst_left <= RST_CYCLES;
        end else if (rst_left > 1) begin
            rst_left <= rst_left - 1;
        end else begin
            RST      <= 1'b0;
            rst_left <= 0;
        end
    end

endmodule

// File: jam_top.sv
module jam_top #(
    parameter int N = 8
) (
    input  logic            CLK,
    input  logic            RST,
    input  jam_pkg::cost_t  Cost,
    output jam_pkg::idx_t   W,
    output jam_pkg::idx_t   J,
    output jam_pkg::sum_t   MinCost,
    output jam_pkg::count_t MatchCount,
    output logic            Valid
);

    // ----------------------------------------
    // internal wires
    // ----------------------------------------

    // controller handshakes
    logic                  step_start;
    logic                  step_done;
    logic                  is_last;
    logic                  scan_start;
    logic                  finish;

    // scan results
    logic                  scan_end;
    logic                  scan_full;
    jam_pkg::sum_t         scan_sum;
    logic                  have_min;

    // current assignment, entry w is the job of worker w
    jam_pkg::idx_t [N-1:0] perm;

    // ----------------------------------------
    // instances
    // ----------------------------------------
    jam_ctrl #(
        .N (N)
    ) u_ctrl (
        .CLK        (CLK),
        .RST        (RST),
        .step_done  (step_done),
        .scan_end   (scan_end),
        .is_last    (is_last),
        .step_start (step_start),
        .scan_start (scan_start),
        .finish     (finish)
    );

    perm_engine #(
        .N (N)
    ) u_perm (
        .CLK        (CLK),
        .RST        (RST),
        .step_start (step_start),
        .step_done  (step_done),
        .is_last    (is_last),
        .perm       (perm)
    );

    // reads the running minimum straight off the output
    cost_scanner #(
        .N (N)
    ) u_scan (
        .CLK        (CLK),
        .RST        (RST),
        .scan_start (scan_start),
        .perm       (perm),
        .Cost       (Cost),
        .min_cost   (MinCost),
        .have_min   (have_min),
        .W          (W),
        .J          (J),
        .scan_end   (scan_end),
        .scan_full  (scan_full),
        .scan_sum   (scan_sum)
    );

    min_tracker u_min (
        .CLK        (CLK),
        .RST        (RST),
        .scan_end   (scan_end),
        .scan_full  (scan_full),
        .scan_sum   (scan_sum),
        .finish     (finish),
        .min_cost   (MinCost),
        .have_min   (have_min),
        .MatchCount (MatchCount),
        .Valid      (Valid)
    );

endmodule

// File: min_tracker.sv
module min_tracker (
    input  logic            CLK,
    input  logic            RST,
    input  logic            scan_end,
    input  logic            scan_full,
    input  jam_pkg::sum_t   scan_sum,
    input  logic            finish,
    output jam_pkg::sum_t   min_cost,
    output logic            have_min,
    output jam_pkg::count_t MatchCount,
    output logic            Valid
);

    logic new_best;
    logic tie;

    // ----------------------------------------
    // compare against the best so far
    // ----------------------------------------

    // first complete sum always wins
    assign new_best = ~have_min || (scan_sum < min_cost);
    assign tie      = have_min && (scan_sum == min_cost);

    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            min_cost   <= '0;
            have_min   <= 1'b0;
            MatchCount <= '0;
            Valid      <= 1'b0;
        end else begin
            // only complete scans count
            if (scan_end && scan_full) begin
                if (new_best) begin
                    min_cost   <= scan_sum;
                    have_min   <= 1'b1;
                    MatchCount <= 16'd1;
                end else if (tie) begin
                    MatchCount <= MatchCount + 1'b1;
                end
            end
            // one-cycle result strobe
            Valid <= finish;
        end
    end

endmodule

// File: cost_scanner.sv
module cost_scanner #(
    parameter int N = 8
) (
    input  logic                  CLK,
    input  logic                  RST,
    input  logic                  scan_start,
    input  jam_pkg::idx_t [N-1:0] perm,
    input  jam_pkg::cost_t        Cost,
    input  jam_pkg::sum_t         min_cost,
    input  logic                  have_min,
    output jam_pkg::idx_t         W,
    output jam_pkg::idx_t         J,
    output logic                  scan_end,
    output logic                  scan_full,
    output jam_pkg::sum_t         scan_sum
);

    logic          busy;
    jam_pkg::idx_t wkr;
    jam_pkg::sum_t acc;
    jam_pkg::sum_t acc_next;
    logic          last_wkr;
    logic          over;

    // ----------------------------------------
    // table address
    // ----------------------------------------

    // worker from the counter, job from the permutation
    assign W = wkr;
    assign J = perm[wkr];

    // ----------------------------------------
    // running sum and abandon check
    // ----------------------------------------
    assign acc_next = acc + jam_pkg::sum_t'(Cost);
    assign last_wkr = (wkr == jam_pkg::idx_t'(N - 1));

    // strictly above the best so far, no tie can be lost
    assign over = have_min && (acc_next > min_cost);

    // sum is complete once the counter stops
    assign scan_sum = acc;

    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            busy      <= 1'b0;
            wkr       <= '0;
            acc       <= '0;
            scan_end  <= 1'b0;
            scan_full <= 1'b0;
        end else begin
            scan_end <= 1'b0;
            if (scan_start) begin
                busy <= 1'b1;
                wkr  <= '0;
                acc  <= '0;
            end else if (busy) begin
                // Cost for the pair on W/J is taken on this edge
                acc <= acc_next;
                if (last_wkr || over) begin
                    busy      <= 1'b0;
                    scan_end  <= 1'b1;
                    // low when cut short
                    scan_full <= ~over;
                end else begin
                    wkr <= wkr + 1'b1;
                end
            end
        end
    end

endmodule

// File: perm_engine.sv
module perm_engine #(
    parameter int N = 8
) (
    input  logic                  CLK,
    input  logic                  RST,
    input  logic                  step_start,
    output logic                  step_done,
    output logic                  is_last,
    output jam_pkg::idx_t [N-1:0] perm
);

    // internal stepping phases
    typedef enum logic [1:0] {
        PH_IDLE,
        PH_PIVOT,
        PH_SUCC,
        PH_SWAP
    } phase_e;

    phase_e                phase;
    jam_pkg::idx_t         sidx;
    jam_pkg::idx_t         pivot;
    jam_pkg::idx_t         succ;
    jam_pkg::idx_t [N-1:0] swapped;
    jam_pkg::idx_t [N-1:0] next_perm;
    logic                  pivot_hit;
    logic                  succ_hit;

    // ----------------------------------------
    // search compares
    // ----------------------------------------

    // pivot: job below its right neighbour
    assign pivot_hit = perm[sidx] < perm[sidx + 1'b1];

    // successor: job above the pivot job
    assign succ_hit = perm[sidx] > perm[pivot];

    // ----------------------------------------
    // exchange and suffix reversal
    // ----------------------------------------
    always_comb begin
        swapped        = perm;
        swapped[pivot] = perm[succ];
        swapped[succ]  = perm[pivot];
        next_perm      = swapped;
        // mirror everything right of the pivot
        for (int i = 0; i < N; i++) begin
            if (i > int'(pivot)) begin
                next_perm[i] = swapped[N + int'(pivot) - i];
            end
        end
    end

    // ----------------------------------------
    // last permutation detect
    // ----------------------------------------
    always_comb begin
        is_last = 1'b1;
        for (int i = 0; i < N; i++) begin
            if (perm[i] != jam_pkg::idx_t'(N - 1 - i)) begin
                is_last = 1'b0;
            end
        end
    end

    // ----------------------------------------
    // phase sequencing and permutation store
    // ----------------------------------------
    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            phase     <= PH_IDLE;
            step_done <= 1'b0;
            // worker w starts on job w
            for (int i = 0; i < N; i++) begin
                perm[i] <= jam_pkg::idx_t'(i);
            end
        end else begin
            step_done <= 1'b0;
            case (phase)
                PH_IDLE: begin
                    if (step_start) begin
                        phase <= PH_PIVOT;
                    end
                end
                PH_PIVOT: begin
                    if (pivot_hit) begin
                        phase <= PH_SUCC;
                    end
                end
                PH_SUCC: begin
                    // always found before reaching the pivot
                    if (succ_hit) begin
                        phase <= PH_SWAP;
                    end
                end
                default: begin
                    // swap and reverse together, single cycle
                    perm      <= next_perm;
                    step_done <= 1'b1;
                    phase     <= PH_IDLE;
                end
            endcase
        end
    end

    // search index and found positions
    always_ff @(posedge CLK) begin
        case (phase)
            PH_IDLE: begin
                sidx <= jam_pkg::idx_t'(N - 2);
            end
            PH_PIVOT: begin
                if (pivot_hit) begin
                    pivot <= sidx;
                    sidx  <= jam_pkg::idx_t'(N - 1);
                end else begin
                    sidx <= sidx - 1'b1;
                end
            end
            PH_SUCC: begin
                if (succ_hit) begin
                    succ <= sidx;
                end else begin
                    sidx <= sidx - 1'b1;
                end
            end
            default: begin
                sidx <= jam_pkg::idx_t'(N - 2);
            end
        endcase
    end

endmodule

// File: jam_ctrl.sv
module jam_ctrl #(
    parameter int N = 8
) (
    input  logic CLK,
    input  logic RST,
    input  logic step_done,
    input  logic scan_end,
    input  logic is_last,
    output logic step_start,
    output logic scan_start,
    output logic finish
);

    jam_pkg::jam_state_e state;
    jam_pkg::jam_state_e nxt_state;
    logic                boot;
    logic                step_go;
    logic                scan_go;
    logic                fin_go;

    // ----------------------------------------
    // next state and pulse decode
    // ----------------------------------------
    always_comb begin
        nxt_state = state;
        step_go   = 1'b0;
        scan_go   = 1'b0;
        fin_go    = 1'b0;
        case (state)
            jam_pkg::ST_SCAN: begin
                // descending order just scanned, nothing left to step to
                if (scan_end) begin
                    if (is_last) begin
                        nxt_state = jam_pkg::ST_DONE;
                        fin_go    = 1'b1;
                    end else begin
                        nxt_state = jam_pkg::ST_STEP;
                        step_go   = 1'b1;
                    end
                end
            end
            jam_pkg::ST_STEP: begin
                // successor ready, go sum it
                if (step_done) begin
                    nxt_state = jam_pkg::ST_SCAN;
                    scan_go   = 1'b1;
                end
            end
            default: nxt_state = jam_pkg::ST_DONE;
        endcase
    end

    // ----------------------------------------
    // registers
    // ----------------------------------------
    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            // identity is already in place, so start by scanning
            state      <= jam_pkg::ST_SCAN;
            boot       <= 1'b1;
            step_start <= 1'b0;
            scan_start <= 1'b0;
            finish     <= 1'b0;
        end else begin
            state      <= nxt_state;
            boot       <= 1'b0;
            step_start <= step_go;
            // first scan kicked by boot, the rest by step_done
            scan_start <= scan_go | boot;
            finish     <= fin_go;
        end
    end

endmodule

// File: jam_pkg.sv
package jam_pkg;

    // ----------------------------------------
    // sizes
    // ----------------------------------------

    // largest worker count the index type can address
    localparam int MAX_N = 8;

    // ----------------------------------------
    // data types
    // ----------------------------------------

    // worker or job index
    typedef logic [$clog2(MAX_N)-1:0] idx_t;

    // one table entry, 0 to 127
    typedef logic [6:0] cost_t;

    // total over up to eight workers
    // 8 * 127 = 1016 still fits
    typedef logic [9:0] sum_t;

    // number of permutations reaching the minimum
    // must hold 8! = 40320
    typedef logic [15:0] count_t;

    // ----------------------------------------
    // controller states
    // ----------------------------------------

    // step  -> perm engine walks to the successor
    // scan  -> cost scanner sums the current permutation
    // done  -> search complete, wait for reset
    typedef enum logic [2:0] {
        ST_STEP,
        ST_SCAN,
        ST_DONE
    } jam_state_e;

endpackage
